/* src/sincos_pkg.sv */
package sincos_pkg;

        // ~~~~~~~~~~~~~~~~~~~~
        // widths
        // ~~~~~~~~~~~~~~~~~~~~
        localparam int PHASE_WIDTH  = 8;
        localparam int SAMPLE_WIDTH = 10;
        localparam int INDEX_WIDTH  = PHASE_WIDTH - 2;   // position inside one quadrant
        localparam int MAG_WIDTH    = SAMPLE_WIDTH - 1;  // first quadrant is never negative
        localparam int ROM_DEPTH    = 1 << INDEX_WIDTH;

        // top two phase bits
        typedef enum logic [1:0] {
                Q0 = 2'd0,
                Q1 = 2'd1,
                Q2 = 2'd2,
                Q3 = 2'd3
        } quadrant_e;

        // ~~~~~~~~~~~~~~~~~~~~
        // pipeline payloads
        // ~~~~~~~~~~~~~~~~~~~~
        typedef struct packed {
                logic [INDEX_WIDTH-1:0] index;   // mirrored table address
                logic                   negate;
        } table_req_t;

        typedef struct packed {
                table_req_t sin;
                table_req_t cos;
        } sin_cos_req_t;

        typedef struct packed {
                logic [MAG_WIDTH-1:0] sin;
                logic [MAG_WIDTH-1:0] cos;
        } sin_cos_mag_t;

        typedef struct packed {
                logic signed [SAMPLE_WIDTH-1:0] sin;
                logic signed [SAMPLE_WIDTH-1:0] cos;
        } sin_cos_sample_t;

endpackage

/* src/phase_decode.sv */
`timescale 1ns/100ps

module phase_decode (
        input  logic                                CLK,
        input  logic                                RESET,
        input  logic                                CE,
        input  logic [sincos_pkg::PHASE_WIDTH-1:0]  phase,
        output sincos_pkg::sin_cos_req_t            req
);

        logic [sincos_pkg::PHASE_WIDTH-1:0] phase_q;
        sincos_pkg::quadrant_e              sin_quad;
        sincos_pkg::quadrant_e              cos_quad;
        logic [sincos_pkg::INDEX_WIDTH-1:0] position;

        // one lookup request from a quadrant and the position inside it
        function automatic sincos_pkg::table_req_t make_req(
                input sincos_pkg::quadrant_e              quad,
                input logic [sincos_pkg::INDEX_WIDTH-1:0] pos
        );
                sincos_pkg::table_req_t r;
                logic                   mirror;
                mirror   = (quad == sincos_pkg::Q1) || (quad == sincos_pkg::Q3);
                r.index  = pos ^ {sincos_pkg::INDEX_WIDTH{mirror}};  // odd quadrants run backwards
                r.negate = (quad == sincos_pkg::Q2) || (quad == sincos_pkg::Q3);
                return r;
        endfunction

        always_ff @(posedge CLK) begin
                if (RESET) begin
                        phase_q <= '0;
                end else if (CE) begin
                        phase_q <= phase;
                end
        end

        assign sin_quad = sincos_pkg::quadrant_e'(
                phase_q[sincos_pkg::PHASE_WIDTH-1 -: 2]);
        // cosine leads sine by a quarter turn, wrapping Q3 back to Q0
        assign cos_quad = sincos_pkg::quadrant_e'(sin_quad + 2'd1);
        assign position = phase_q[sincos_pkg::INDEX_WIDTH-1:0];

        always_comb begin
                req.sin = make_req(sin_quad, position);
                req.cos = make_req(cos_quad, position);
        end

endmodule

/* src/quarter_sine_rom.sv */
`timescale 1ns/100ps

module quarter_sine_rom (
        input  logic                     CLK,
        input  logic                     RESET,
        input  logic                     CE,
        input  sincos_pkg::sin_cos_req_t req,
        output sincos_pkg::sin_cos_mag_t mag
);

        // ~~~~~~~~~~~~~~~~~~~~
        // first quadrant table
        // ~~~~~~~~~~~~~~~~~~~~
        // word i holds round(511 * sin(2*pi*(i+0.5)/256)), so it never reaches zero
        (* ram_style = "block" *)
        logic [sincos_pkg::MAG_WIDTH-1:0] memory [0:sincos_pkg::ROM_DEPTH-1];

        initial begin
                $readmemh("src/quarter_sine.hex", memory);
        end

        sincos_pkg::sin_cos_mag_t rd_q;   // read stage
        sincos_pkg::sin_cos_mag_t out_q;  // output stage

        // both channels share the table, one read each per cycle
        always_ff @(posedge CLK) begin
                if (RESET) begin
                        rd_q <= '0;
                end else if (CE) begin
                        rd_q.sin <= memory[req.sin.index];
                        rd_q.cos <= memory[req.cos.index];
                end
        end

        always_ff @(posedge CLK) begin
                if (RESET) begin
                        out_q <= '0;
                end else if (CE) begin
                        out_q <= rd_q;
                end
        end

        assign mag = out_q;

endmodule

/* src/sign_restore.sv */
`timescale 1ns/100ps

module sign_restore (
        input  logic                        CLK,
        input  logic                        RESET,
        input  logic                        CE,
        input  sincos_pkg::sin_cos_req_t    req,
        input  sincos_pkg::sin_cos_mag_t    mag,
        output sincos_pkg::sin_cos_sample_t sample
);

        logic [1:0] negate_d1;  // bit 1 is sine, bit 0 is cosine
        logic [1:0] negate_d2;

        sincos_pkg::sin_cos_sample_t sample_q;

        // widen the magnitude by a zero sign bit, then flip it if asked
        function automatic logic signed [sincos_pkg::SAMPLE_WIDTH-1:0] apply_sign(
                input logic [sincos_pkg::MAG_WIDTH-1:0] m,
                input logic                             neg
        );
                logic signed [sincos_pkg::SAMPLE_WIDTH-1:0] ext;
                ext = {1'b0, m};
                return neg ? -ext : ext;
        endfunction

        // ~~~~~~~~~~~~~~~~~~~~
        // flags follow the two ROM stages
        // ~~~~~~~~~~~~~~~~~~~~
        always_ff @(posedge CLK) begin
                if (RESET) begin
                        negate_d1 <= '0;
                        negate_d2 <= '0;
                end else if (CE) begin
                        negate_d1 <= {req.sin.negate, req.cos.negate};
                        negate_d2 <= negate_d1;
                end
        end

        always_ff @(posedge CLK) begin
                if (RESET) begin
                        sample_q <= '0;
                end else if (CE) begin
                        sample_q.sin <= apply_sign(mag.sin, negate_d2[1]);
                        sample_q.cos <= apply_sign(mag.cos, negate_d2[0]);
                end
        end

        assign sample = sample_q;

endmodule

/* src/sin_cos_table.sv */
`timescale 1ns/100ps

module sin_cos_table (
        input  logic                                CLK,
        input  logic                                RESET,
        input  logic                                CE,
        input  logic [sincos_pkg::PHASE_WIDTH-1:0]  phase,
        output sincos_pkg::sin_cos_sample_t         sample
);

        sincos_pkg::sin_cos_req_t req;  // valid one enabled edge after phase
        sincos_pkg::sin_cos_mag_t mag;  // valid two enabled edges after req

        // ~~~~~~~~~~~~~~~~~~~~
        // four stage pipeline
        // ~~~~~~~~~~~~~~~~~~~~
        phase_decode u_phase_decode (
                .CLK   (CLK),
                .RESET (RESET),
                .CE    (CE),
                .phase (phase),
                .req   (req)
        );

        quarter_sine_rom u_quarter_sine_rom (
                .CLK   (CLK),
                .RESET (RESET),
                .CE    (CE),
                .req   (req),
                .mag   (mag)
        );

        // the negate flags are taken straight from req and delayed inside
        sign_restore u_sign_restore (
                .CLK    (CLK),
                .RESET  (RESET),
                .CE     (CE),
                .req    (req),
                .mag    (mag),
                .sample (sample)
        );

endmodule

/* dv/sin_cos_table_asserts.sv */
`timescale 1ns/100ps

module sin_cos_table_asserts (
        input logic                        CLK,
        input logic                        RESET,
        input logic                        CE,
        input sincos_pkg::sin_cos_sample_t sample
);

        localparam logic [sincos_pkg::SAMPLE_WIDTH-1:0] MOST_NEGATIVE =
                {1'b1, {(sincos_pkg::SAMPLE_WIDTH-1){1'b0}}};

        // ~~~~~~~~~~~~~~~~~~~~
        // output behavior
        // ~~~~~~~~~~~~~~~~~~~~
        hold_when_paused: assert property (@(posedge CLK)
                (!CE && !RESET) |=> $stable(sample))
                else $error("sample moved on an edge with CE low");

        zero_after_reset: assert property (@(posedge CLK)
                RESET |=> (sample == '0))
                else $error("sample not cleared by reset");

        // magnitudes stop at 511, so -512 can never be formed
        no_most_negative: assert property (@(posedge CLK) disable iff (RESET)
                (sample.sin != MOST_NEGATIVE) && (sample.cos != MOST_NEGATIVE))
                else $error("sample took the most negative value");

endmodule

bind sin_cos_table sin_cos_table_asserts u_asserts (
        .CLK    (CLK),
        .RESET  (RESET),
        .CE     (CE),
        .sample (sample)
);

/* dv/tb_sin_cos_table.sv */
`timescale 1ns/100ps

module tb_sin_cos_table;

        localparam int CYCLE_LIMIT = 2000;  // the tests need roughly 650 cycles
        localparam int LATENCY     = 4;

        logic                                 CLK = 1'b0;
        logic                                 RESET;
        logic                                 CE;
        logic [sincos_pkg::PHASE_WIDTH-1:0]   phase;
        sincos_pkg::sin_cos_sample_t          sample;

        logic [15:0]                          lfsr_state;
        logic [sincos_pkg::PHASE_WIDTH-1:0]   in_flight [$];  // phases taken, not yet checked
        logic [sincos_pkg::PHASE_WIDTH-1:0]   last_checked;   // phase whose sample is on the output
        string                                test_name;
        int                                   checks;
        int                                   errors;
        int                                   test_checks;
        int                                   test_errors;
        int                                   cycles;

        sin_cos_table uut (
                .CLK    (CLK),
                .RESET  (RESET),
                .CE     (CE),
                .phase  (phase),
                .sample (sample)
        );

        always #20 CLK = ~CLK;

        // ~~~~~~~~~~~~~~~~~~~~
        // helpers
        // ~~~~~~~~~~~~~~~~~~~~
        // taps 16, 14, 13, 11
        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                logic fb;
                fb = s[15] ^ s[13] ^ s[12] ^ s[10];
                return {s[14:0], fb};
        endfunction

        task automatic random_bits(input int n, output logic [7:0] v);
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        v = {v[6:0], lfsr_state[0]};
                end
        endtask

        function automatic logic signed [sincos_pkg::SAMPLE_WIDTH-1:0] expected_sample(
                input logic [sincos_pkg::PHASE_WIDTH-1:0] ph,
                input logic                               cos_channel
        );
                logic [1:0]                                 quad;
                logic [sincos_pkg::INDEX_WIDTH-1:0]         idx;
                logic signed [sincos_pkg::SAMPLE_WIDTH-1:0] r;
                real                                        angle;
                int                                         mag;
                quad  = ph[7:6] + {1'b0, cos_channel};  // cosine is one quadrant ahead
                idx   = ph[5:0];
                if (quad[0]) idx = ~idx;
                angle = 2.0 * 3.14159265358979 * (real'(idx) + 0.5) / 256.0;
                mag   = $rtoi(511.0 * $sin(angle) + 0.5);
                r     = mag[sincos_pkg::SAMPLE_WIDTH-1:0];
                if (quad[1]) r = -r;
                return r;
        endfunction

        task automatic drive_cycle(input logic ce_val, input logic [7:0] ph);
                @(negedge CLK);
                CE    = ce_val;
                phase = ph;
                if (ce_val) in_flight.push_back(ph);
        endtask

        // pushes the last phases of a test through the pipeline
        task automatic drain;
                repeat (LATENCY - 1) drive_cycle(1'b1, 8'd0);
        endtask

        task automatic start_test(input string name);
                test_name   = name;
                test_checks = checks;
                test_errors = errors;
        endtask

        task automatic finish_test;
                @(negedge CLK);
                CE = 1'b0;
                $display("test %s done: %0d checks, %0d errors", test_name,
                         checks - test_checks, errors - test_errors);
        endtask

        // ~~~~~~~~~~~~~~~~~~~~
        // checker
        // ~~~~~~~~~~~~~~~~~~~~
        always begin : compare_outputs
                logic                                       en;
                logic [sincos_pkg::PHASE_WIDTH-1:0]         ph;
                logic signed [sincos_pkg::SAMPLE_WIDTH-1:0] exp_sin;
                logic signed [sincos_pkg::SAMPLE_WIDTH-1:0] exp_cos;
                @(posedge CLK);
                en = CE && !RESET;
                #1;  // let the registers settle
                if (en && in_flight.size() == LATENCY) begin
                        ph           = in_flight.pop_front();
                        last_checked = ph;
                        exp_sin      = expected_sample(ph, 1'b0);
                        exp_cos      = expected_sample(ph, 1'b1);
                        checks += 2;
                        if (sample.sin !== exp_sin) begin
                                errors++;
                                $display("Mismatch in %s (phase %0d sin): expected %0d, actual %0d",
                                         test_name, ph, exp_sin, sample.sin);
                        end
                        if (sample.cos !== exp_cos) begin
                                errors++;
                                $display("Mismatch in %s (phase %0d cos): expected %0d, actual %0d",
                                         test_name, ph, exp_cos, sample.cos);
                        end
                end
        end

        always @(posedge CLK) begin
                cycles++;
                if (cycles >= CYCLE_LIMIT) begin
                        $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
                        $display("ERRORS FOUND");
                        $finish;
                end
        end

        // ~~~~~~~~~~~~~~~~~~~~
        // stimulus
        // ~~~~~~~~~~~~~~~~~~~~
        initial begin : stimulus
                logic [7:0]                  boundary [8];
                logic [7:0]                  ph;
                logic [7:0]                  ce_bit;
                sincos_pkg::sin_cos_sample_t held;
                RESET      = 1'b1;
                CE         = 1'b0;
                phase      = '0;
                lfsr_state = 16'd56;
                checks     = 0;
                errors     = 0;
                cycles     = 0;
                boundary   = '{8'd63, 8'd64, 8'd127, 8'd128, 8'd191, 8'd192, 8'd255, 8'd0};

                repeat (3) @(negedge CLK);
                RESET = 1'b0;

                start_test("reset");
                @(negedge CLK);
                checks++;
                if (sample !== '0) begin
                        errors++;
                        $display("Mismatch in %s: expected 0, actual %h", test_name, sample);
                end
                finish_test();

                start_test("full_sweep");
                for (int i = 0; i < 256; i++) drive_cycle(1'b1, 8'(i));
                drain();
                finish_test();

                start_test("quadrant_boundaries");
                for (int i = 0; i < 8; i++) drive_cycle(1'b1, boundary[i]);
                drain();
                finish_test();

                start_test("pipeline_pause");
                ph = 8'd5;
                for (int i = 0; i < 6; i++) begin
                        drive_cycle(1'b1, ph);
                        ph = ph + 8'd37;
                end
                @(negedge CLK);
                CE       = 1'b0;
                held.sin = expected_sample(last_checked, 1'b0);  // the last sample stays put
                held.cos = expected_sample(last_checked, 1'b1);
                repeat (5) begin
                        @(negedge CLK);
                        checks++;
                        if (sample !== held) begin
                                errors++;
                                $display("Mismatch in %s (hold): expected %h, actual %h",
                                         test_name, held, sample);
                        end
                end
                for (int i = 0; i < 6; i++) begin
                        drive_cycle(1'b1, ph);
                        ph = ph + 8'd37;
                end
                drain();
                finish_test();

                start_test("random_traffic");
                repeat (300) begin
                        random_bits(1, ce_bit);
                        random_bits(8, ph);
                        drive_cycle(ce_bit[0], ph);
                end
                drain();
                finish_test();

                $display("%0d checks, %0d errors", checks, errors);
                if (errors == 0) begin
                        $display("NO ERRORS");
                end else begin
                        $display("ERRORS FOUND");
                end
                $finish;
        end

endmodule

/* src/quarter_sine.hex */
// one 9-bit first-quadrant magnitude per line, word i = round(511*sin(2*pi*(i+0.5)/256))
006
013
01f
02c
038
045
051
05e
06a
076
082
08e
09a
0a6
0b2
0be
0c9
0d5
0e0
0eb
0f6
101
10c
117
121
12b
135
13f
149
152
15c
165
16e
176
17f
187
18f
197
19e
1a5
1ac
1b3
1b9
1c0
1c6
1cb
1d1
1d6
1da
1df
1e3
1e7
1eb
1ee
1f1
1f4
1f6
1f9
1fa
1fc
1fd
1fe
1ff
1ff

/* tb.f */
src/sincos_pkg.sv
src/phase_decode.sv
src/quarter_sine_rom.sv
src/sign_restore.sv
src/sin_cos_table.sv
dv/sin_cos_table_asserts.sv
dv/tb_sin_cos_table.sv

/* run.sh */
#!/bin/sh
# build and run from the project root; the exit status follows the testbench result
verilator --binary --timing --assert -f tb.f --top-module tb_sin_cos_table -o sim_tb \
        && ./obj_dir/sim_tb > sim.log 2>&1 \
        && cat sim.log \
        && ! grep -q "ERRORS FOUND" sim.log \
        && echo "simulation passed" \
        || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
